/* list.f */
hw/cache_geometry_pkg.sv
hw/cache_access_pkg.sv
hw/dcache_way_if.sv
hw/dcache_tag_store.sv
hw/dcache_lru.sv
hw/dcache_data_store.sv
hw/dcache_top.sv
bench/tb_clock.sv
bench/dcache_checker.sv
bench/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - hw/cache_geometry_pkg.sv
  - hw/cache_access_pkg.sv
  - hw/dcache_way_if.sv
  - hw/dcache_tag_store.sv
  - hw/dcache_lru.sv
  - hw/dcache_data_store.sv
  - hw/dcache_top.sv
  - target: simulation
    files:
      - bench/tb_clock.sv
      - bench/dcache_checker.sv
      - bench/dcache_tb.sv

/* bench/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;

    localparam int SET_COUNT   = cache_geometry_pkg::DEF_SET_COUNT;
    localparam int BLOCK_WIDTH = cache_geometry_pkg::DEF_BLOCK_WIDTH;
    localparam int ADDR_WIDTH  = cache_geometry_pkg::DEF_ADDR_WIDTH;
    localparam int DATA_WIDTH  = cache_geometry_pkg::DATA_WIDTH;
    localparam int WAYS        = cache_geometry_pkg::WAY_COUNT;
    localparam int BUS_W       = cache_geometry_pkg::BUS_ADDR_WIDTH;
    localparam int ST_W        = cache_access_pkg::STORE_TYPE_W;
    localparam int WORDS       = BLOCK_WIDTH / cache_geometry_pkg::WORD_WIDTH;
    localparam int BO_W        = cache_geometry_pkg::BYTE_OFFSET_W;
    localparam int WO_W        = $clog2(WORDS);
    localparam int IDX_W       = $clog2(SET_COUNT);
    localparam int IDX_LSB     = WO_W + BO_W;
    localparam int TAG_LSB     = IDX_LSB + IDX_W;
    localparam int TAG_W       = ADDR_WIDTH - TAG_LSB;

    // Each operation takes one cycle.
    localparam int STORES      = 40;
    localparam int ROUNDS      = 12;
    localparam int TOTAL_OPS   = 8 + SET_COUNT * WAYS * (1 + WORDS) + STORES
                               + SET_COUNT * WAYS * WORDS + 32 + 6 * ROUNDS;
    localparam int CYCLE_LIMIT = 4 * TOTAL_OPS + 100;

    logic                   clk;
    logic                   arst;
    logic                   write_en;
    logic                   valid_update;
    logic                   lru_update;
    logic                   block_write_en;
    logic                   addr_control;
    logic [ADDR_WIDTH-1:0]  data_addr;
    logic [DATA_WIDTH-1:0]  wdata;
    logic [DATA_WIDTH-1:0]  rdata;
    logic [BLOCK_WIDTH-1:0] refill_block;
    logic [BLOCK_WIDTH-1:0] victim_block;
    logic [ST_W-1:0]        store_type;
    logic                   hit;
    logic                   dirty;
    logic                   store_ma;
    logic [BUS_W-1:0]       addr_axi;

    // Reference model of the cache state.
    logic [TAG_W-1:0]       m_tag   [SET_COUNT][WAYS];
    logic [BLOCK_WIDTH-1:0] m_block [SET_COUNT][WAYS];
    bit                     m_valid [SET_COUNT][WAYS];
    bit                     m_dirty [SET_COUNT][WAYS];
    int                     m_rank  [SET_COUNT][WAYS];

    logic [31:0] rng_state;
    int          cycle_count;
    int          checks;
    int          fails;
    int          test_checks;
    int          test_fails;

    tb_clock clock_i (
        .o_clk (clk)
    );

    dcache_top #(
        .SET_COUNT   (SET_COUNT),
        .BLOCK_WIDTH (BLOCK_WIDTH),
        .ADDR_WIDTH  (ADDR_WIDTH)
    ) dcache_top_i (
        .clk             (clk),
        .arst            (arst),
        .write_en        (write_en),
        .valid_update    (valid_update),
        .lru_update      (lru_update),
        .block_write_en  (block_write_en),
        .i_data_addr     (data_addr),
        .i_data          (wdata),
        .i_data_block    (refill_block),
        .i_store_type    (store_type),
        .i_addr_control  (addr_control),
        .o_data          (rdata),
        .o_data_block    (victim_block),
        .o_hit           (hit),
        .o_dirty         (dirty),
        .o_addr_axi      (addr_axi),
        .o_store_addr_ma (store_ma)
    );

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Low LCG bits have short periods.
    function automatic int pick(int n);
        return int'((next_random() >> 8) % n);
    endfunction

    function automatic logic [BLOCK_WIDTH-1:0] random_bits();
        logic [BLOCK_WIDTH-1:0] v;
        for (int i = 0; i < BLOCK_WIDTH / 32; i++) begin
            v[i*32 +: 32] = next_random();
        end
        return v;
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] make_addr(logic [TAG_W-1:0] tag, int s, int wo,
                                                        int bo);
        return {tag, IDX_W'(s), WO_W'(wo), BO_W'(bo)};
    endfunction

    function automatic int victim_of(int s);
        for (int w = 0; w < WAYS; w++) begin
            if (m_rank[s][w] == 0) begin
                return w;
            end
        end
        return 0;
    endfunction

    function automatic int hit_way(int s, logic [TAG_W-1:0] tag);
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == tag) begin
                return w;
            end
        end
        return -1;
    endfunction

    // Two words from the offset on with zeros past the block end.
    function automatic logic [DATA_WIDTH-1:0] window(logic [BLOCK_WIDTH-1:0] blk, int wo);
        logic [31:0] upper;
        upper = (wo == WORDS - 1) ? 32'd0 : blk[(wo+1)*32 +: 32];
        return {upper, blk[wo*32 +: 32]};
    endfunction

    function automatic bit misaligned(int st, int wo, int bo);
        case (st)
            cache_access_pkg::STORE_HALF:   return bo[0];
            cache_access_pkg::STORE_WORD:   return bo != 0;
            cache_access_pkg::STORE_DOUBLE: return bo != 0 || wo[0];
            default:                        return 1'b0;
        endcase
    endfunction

    task automatic report_mismatch(string what, logic [BLOCK_WIDTH-1:0] got,
                                   logic [BLOCK_WIDTH-1:0] exp);
        test_fails++;
        $display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, exp);
    endtask

    // ------------------------------------------------------------------------
    // Compare outputs with the model, then apply the strobes to the model.
    // ------------------------------------------------------------------------

    task automatic check_and_apply();
        int s;
        int wo;
        int bo;
        int hw;
        int vic;
        int mw;
        int rm;
        logic [TAG_W-1:0] tag;
        logic [BUS_W-1:0] exp_axi;
        s   = data_addr[TAG_LSB-1:IDX_LSB];
        wo  = data_addr[IDX_LSB-1:BO_W];
        bo  = data_addr[BO_W-1:0];
        tag = data_addr[ADDR_WIDTH-1:TAG_LSB];
        hw  = hit_way(s, tag);
        vic = victim_of(s);
        mw  = (hw >= 0) ? hw : vic;
        test_checks++;
        if (hit !== (hw >= 0)) report_mismatch("o_hit", hit, hw >= 0);
        if (dirty !== m_dirty[s][vic]) report_mismatch("o_dirty", dirty, m_dirty[s][vic]);
        if (hw >= 0 && rdata !== window(m_block[s][hw], wo))
            report_mismatch("o_data", rdata, window(m_block[s][hw], wo));
        if (store_ma !== misaligned(store_type, wo, bo))
            report_mismatch("o_store_addr_ma", store_ma, misaligned(store_type, wo, bo));
        if (m_valid[s][vic] && victim_block !== m_block[s][vic])
            report_mismatch("o_data_block", victim_block, m_block[s][vic]);
        // Block start of the miss line or of the victim line.
        if (addr_control) begin
            exp_axi = BUS_W'(make_addr(tag, s, 0, 0));
        end else begin
            exp_axi = BUS_W'(make_addr(m_tag[s][vic], s, 0, 0));
        end
        if ((addr_control || m_valid[s][vic]) && addr_axi !== exp_axi)
            report_mismatch("o_addr_axi", addr_axi, exp_axi);

        // Store bytes counted from the byte address in the block.
        if (write_en) begin
            for (int i = 0; i < (1 << store_type); i++) begin
                m_block[s][mw][(wo*4 + bo + i)*8 +: 8] = wdata[i*8 +: 8];
            end
            m_dirty[s][mw] = 1'b1;
        end else if (block_write_en) begin
            m_block[s][vic] = refill_block;
            m_dirty[s][vic] = 1'b0;
        end
        if (block_write_en) m_tag[s][vic] = tag;
        if (valid_update) m_valid[s][vic] = 1'b1;
        if (lru_update) begin
            rm = m_rank[s][mw];
            for (int w = 0; w < WAYS; w++) begin
                if (w == mw) m_rank[s][w] = WAYS - 1;
                else if (m_rank[s][w] > rm) m_rank[s][w]--;
            end
        end
    endtask

    // One operation per cycle. Refills also set valid.
    task automatic drive(logic [ADDR_WIDTH-1:0] addr, logic [ST_W-1:0] st, logic actl,
                         logic wen, logic lupd, logic ben);
        @(posedge clk);
        data_addr      <= addr;
        store_type     <= st;
        addr_control   <= actl;
        write_en       <= wen;
        lru_update     <= lupd;
        block_write_en <= ben;
        valid_update   <= ben;
        wdata          <= DATA_WIDTH'(random_bits());
        refill_block   <= random_bits();
        @(negedge clk);
        check_and_apply();
    endtask

    task automatic end_test(string name);
        $display("%s: %0d checks, %0d failures", name, test_checks, test_fails);
        checks      += test_checks;
        fails       += test_fails;
        test_checks  = 0;
        test_fails   = 0;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles", cycle_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        int s;
        int w;
        int wo;
        int bo;
        int st;
        logic [TAG_W-1:0] tag;
        rng_state      = 32'h8bf2a4ec;
        arst           = 1'b1;
        write_en       = 1'b0;
        valid_update   = 1'b0;
        lru_update     = 1'b0;
        block_write_en = 1'b0;
        addr_control   = 1'b0;
        data_addr      = '0;
        wdata          = '0;
        refill_block   = '0;
        store_type     = '0;
        for (s = 0; s < SET_COUNT; s++) begin
            for (w = 0; w < WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_rank[s][w]  = w;
            end
        end
        repeat (8) @(posedge clk);
        arst <= 1'b0;

        repeat (8) drive(make_addr(TAG_W'(random_bits()), pick(SET_COUNT), pick(WORDS), pick(4)),
                         pick(4), pick(2), 1'b0, 1'b0, 1'b0);
        end_test("reset_miss");

        for (s = 0; s < SET_COUNT; s++) begin
            for (w = 0; w < WAYS; w++) begin
                tag = TAG_W'(random_bits());
                while (hit_way(s, tag) >= 0) tag = TAG_W'(random_bits());
                drive(make_addr(tag, s, 0, 0), 0, 1'b0, 1'b0, 1'b1, 1'b1);
                for (wo = 0; wo < WORDS; wo++) begin
                    drive(make_addr(tag, s, wo, 0), pick(4), pick(2), 1'b0, 1'b0, 1'b0);
                end
            end
        end
        end_test("refill_read");

        repeat (STORES) begin
            s  = pick(SET_COUNT);
            w  = pick(WAYS);
            st = pick(4);
            wo = pick(WORDS);
            // Natural alignment for the store size.
            bo = pick(4) & ~((1 << st) - 1);
            if (st == cache_access_pkg::STORE_DOUBLE) wo = wo & ~1;
            drive(make_addr(m_tag[s][w], s, wo, bo), st, 1'b0, 1'b1, pick(2), 1'b0);
        end
        // Touching the read way first leaves the other way as victim.
        for (s = 0; s < SET_COUNT; s++) begin
            for (w = 0; w < WAYS; w++) begin
                for (wo = 0; wo < WORDS; wo++) begin
                    drive(make_addr(m_tag[s][w], s, wo, 0), 0, pick(2), 1'b0,
                          wo == 0, 1'b0);
                end
            end
        end
        end_test("store_hit");

        repeat (32) drive(make_addr(TAG_W'(random_bits()), pick(SET_COUNT), pick(WORDS), pick(4)),
                          pick(4), pick(2), 1'b0, 1'b0, 1'b0);
        end_test("misalign");

        repeat (ROUNDS) begin
            s = pick(SET_COUNT);
            drive(make_addr(m_tag[s][pick(WAYS)], s, pick(WORDS), 0), 0, 1'b0, pick(2), 1'b1, 1'b0);
            drive(make_addr(m_tag[s][pick(WAYS)], s, pick(WORDS), 0), 0, 1'b0, 1'b0, 1'b1, 1'b0);
            tag = TAG_W'(random_bits());
            while (hit_way(s, tag) >= 0) tag = TAG_W'(random_bits());
            drive(make_addr(tag, s, 0, 0), 0, 1'b0, 1'b0, 1'b0, 1'b0);
            drive(make_addr(tag, s, 0, 0), 0, 1'b1, 1'b0, 1'b0, 1'b0);
            drive(make_addr(tag, s, 0, 0), 0, 1'b0, 1'b0, 1'b1, 1'b1);
            drive(make_addr(tag, s, pick(WORDS), 0), 0, 1'b0, 1'b0, 1'b0, 1'b0);
        end
        end_test("lru_replace");

        $display("Summary: %0d checks, %0d failures", checks, fails);
        if (fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* bench/dcache_checker.sv */
`timescale 1ns/1ps

module dcache_checker #(
    parameter int ADDR_WIDTH = cache_geometry_pkg::DEF_ADDR_WIDTH
) (
    input logic                                      clk,
    input logic                                      arst,
    input logic                                      i_valid_update,
    input logic                                      i_block_write_en,
    input logic [ADDR_WIDTH-1:0]                     i_data_addr,
    input logic [cache_access_pkg::STORE_TYPE_W-1:0] i_store_type,
    input logic                                      i_hit,
    input logic                                      i_store_addr_ma
);

    logic valid_seen;

    // Set once the first line turns valid.
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            valid_seen <= 1'b0;
        end else if (i_valid_update) begin
            valid_seen <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Properties.
    // ------------------------------------------------------------------------

    byte_never_misaligned: assert property (@(posedge clk) disable iff (arst)
        (i_store_type == cache_access_pkg::STORE_BYTE) |-> !i_store_addr_ma)
        else $error("Byte store flagged as misaligned");

    no_hit_before_fill: assert property (@(posedge clk) disable iff (arst)
        !valid_seen |-> !i_hit)
        else $error("Hit reported before any line was made valid");

    refill_gives_hit: assert property (@(posedge clk) disable iff (arst)
        (i_block_write_en && i_valid_update) |=> (!$stable(i_data_addr) || i_hit))
        else $error("Refilled address does not hit in the next cycle");

endmodule

bind dcache_top dcache_checker #(
    .ADDR_WIDTH (ADDR_WIDTH)
) checker_i (
    .clk              (clk),
    .arst             (arst),
    .i_valid_update   (valid_update),
    .i_block_write_en (block_write_en),
    .i_data_addr      (i_data_addr),
    .i_store_type     (i_store_type),
    .i_hit            (o_hit),
    .i_store_addr_ma  (o_store_addr_ma)
);

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 4.0
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    // Toggle every half period.
    always begin
        #(PERIOD_NS / 2.0);
        o_clk = ~o_clk;
    end

endmodule

/* hw/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top #(
    parameter int SET_COUNT   = cache_geometry_pkg::DEF_SET_COUNT,
    parameter int BLOCK_WIDTH = cache_geometry_pkg::DEF_BLOCK_WIDTH,
    parameter int ADDR_WIDTH  = cache_geometry_pkg::DEF_ADDR_WIDTH
) (
    input  logic                                          clk,
    input  logic                                          arst,

    // Strobes from the core control.
    input  logic                                          write_en,
    input  logic                                          valid_update,
    input  logic                                          lru_update,
    input  logic                                          block_write_en,

    // Access and refill inputs.
    input  logic [ADDR_WIDTH-1:0]                         i_data_addr,
    input  logic [cache_geometry_pkg::DATA_WIDTH-1:0]     i_data,
    input  logic [BLOCK_WIDTH-1:0]                        i_data_block,
    input  logic [cache_access_pkg::STORE_TYPE_W-1:0]     i_store_type,
    input  logic                                          i_addr_control,

    // Lookup results and write-back path.
    output logic [cache_geometry_pkg::DATA_WIDTH-1:0]     o_data,
    output logic [BLOCK_WIDTH-1:0]                        o_data_block,
    output logic                                          o_hit,
    output logic                                          o_dirty,
    output logic [cache_geometry_pkg::BUS_ADDR_WIDTH-1:0] o_addr_axi,
    output logic                                          o_store_addr_ma
);

    dcache_way_if #(
        .SET_COUNT (SET_COUNT)
    ) way_bus ();

    // ------------------------------------------------------------------------
    // Tag store.
    // ------------------------------------------------------------------------

    dcache_tag_store #(
        .SET_COUNT   (SET_COUNT),
        .BLOCK_WIDTH (BLOCK_WIDTH),
        .ADDR_WIDTH  (ADDR_WIDTH)
    ) tag_store_i (
        .clk            (clk),
        .arst           (arst),
        .write_en       (write_en),
        .block_write_en (block_write_en),
        .valid_update   (valid_update),
        .i_data_addr    (i_data_addr),
        .i_addr_control (i_addr_control),
        .o_hit          (o_hit),
        .o_dirty        (o_dirty),
        .o_addr_axi     (o_addr_axi),
        .way_if         (way_bus)
    );

    // ------------------------------------------------------------------------
    // Replacement.
    // ------------------------------------------------------------------------

    dcache_lru #(
        .SET_COUNT (SET_COUNT)
    ) lru_i (
        .clk        (clk),
        .arst       (arst),
        .lru_update (lru_update),
        .way_if     (way_bus)
    );

    // ------------------------------------------------------------------------
    // Data store.
    // ------------------------------------------------------------------------

    dcache_data_store #(
        .SET_COUNT   (SET_COUNT),
        .BLOCK_WIDTH (BLOCK_WIDTH),
        .ADDR_WIDTH  (ADDR_WIDTH)
    ) data_store_i (
        .clk             (clk),
        .write_en        (write_en),
        .block_write_en  (block_write_en),
        .i_data_addr     (i_data_addr),
        .i_data          (i_data),
        .i_data_block    (i_data_block),
        .i_store_type    (i_store_type),
        .o_data          (o_data),
        .o_data_block    (o_data_block),
        .o_store_addr_ma (o_store_addr_ma),
        .way_if          (way_bus)
    );

endmodule

/* hw/dcache_data_store.sv */
`timescale 1ns/1ps

module dcache_data_store #(
    parameter int SET_COUNT   = cache_geometry_pkg::DEF_SET_COUNT,
    parameter int BLOCK_WIDTH = cache_geometry_pkg::DEF_BLOCK_WIDTH,
    parameter int ADDR_WIDTH  = cache_geometry_pkg::DEF_ADDR_WIDTH
) (
    input  logic                                      clk,
    input  logic                                      write_en,
    input  logic                                      block_write_en,
    input  logic [ADDR_WIDTH-1:0]                     i_data_addr,
    input  logic [cache_geometry_pkg::DATA_WIDTH-1:0] i_data,
    input  logic [BLOCK_WIDTH-1:0]                    i_data_block,
    input  logic [cache_access_pkg::STORE_TYPE_W-1:0] i_store_type,
    output logic [cache_geometry_pkg::DATA_WIDTH-1:0] o_data,
    output logic [BLOCK_WIDTH-1:0]                    o_data_block,
    output logic                                      o_store_addr_ma,
    dcache_way_if.data                                way_if
);

    localparam int WAY_COUNT     = cache_geometry_pkg::WAY_COUNT;
    localparam int DATA_WIDTH    = cache_geometry_pkg::DATA_WIDTH;
    localparam int WORD_WIDTH    = cache_geometry_pkg::WORD_WIDTH;
    localparam int BYTE_OFFSET_W = cache_geometry_pkg::BYTE_OFFSET_W;
    localparam int WORD_OFFSET_W = $clog2(BLOCK_WIDTH / WORD_WIDTH);
    localparam int BYTE_ADDR_W   = WORD_OFFSET_W + BYTE_OFFSET_W;

    logic [BLOCK_WIDTH-1:0] data_mem [SET_COUNT][WAY_COUNT];

    logic [WORD_OFFSET_W-1:0] word_offset;
    logic [BYTE_OFFSET_W-1:0] byte_offset;
    logic [BYTE_ADDR_W-1:0]   byte_addr;
    logic [BYTE_ADDR_W-1:0]   lane_addr;
    logic [DATA_WIDTH-1:0]    lane_mask;
    logic [BLOCK_WIDTH-1:0]   match_block;
    logic [BLOCK_WIDTH-1:0]   merged_block;
    logic [BLOCK_WIDTH+WORD_WIDTH-1:0] read_ext;

    assign byte_offset = i_data_addr[BYTE_OFFSET_W-1:0];
    assign word_offset = i_data_addr[BYTE_ADDR_W-1:BYTE_OFFSET_W];
    assign byte_addr   = {word_offset, byte_offset};
    assign match_block = data_mem[way_if.index][way_if.match_way];

    // ------------------------------------------------------------------------
    // Store merge.
    // ------------------------------------------------------------------------

    // Lane is the naturally aligned slot holding the addressed byte.
    always_comb begin
        case (i_store_type)
            cache_access_pkg::STORE_BYTE: begin
                lane_mask = DATA_WIDTH'({cache_access_pkg::LANE_BYTE_W{1'b1}});
                lane_addr = byte_addr;
            end
            cache_access_pkg::STORE_HALF: begin
                lane_mask = DATA_WIDTH'({cache_access_pkg::LANE_HALF_W{1'b1}});
                lane_addr = {byte_addr[BYTE_ADDR_W-1:1], 1'b0};
            end
            cache_access_pkg::STORE_WORD: begin
                lane_mask = DATA_WIDTH'({cache_access_pkg::LANE_WORD_W{1'b1}});
                lane_addr = {byte_addr[BYTE_ADDR_W-1:2], 2'b00};
            end
            cache_access_pkg::STORE_DOUBLE: begin
                lane_mask = DATA_WIDTH'({cache_access_pkg::LANE_DOUBLE_W{1'b1}});
                lane_addr = {byte_addr[BYTE_ADDR_W-1:3], 3'b000};
            end
            default: begin
                lane_mask = '0;
                lane_addr = '0;
            end
        endcase
    end

    assign merged_block = (match_block & ~(BLOCK_WIDTH'(lane_mask) << {lane_addr, 3'b000}))
                        | (BLOCK_WIDTH'(i_data & lane_mask) << {lane_addr, 3'b000});

    always_ff @(posedge clk) begin
        if (write_en) begin
            data_mem[way_if.index][way_if.match_way] <= merged_block;
        end else if (block_write_en) begin
            data_mem[way_if.index][way_if.victim_way] <= i_data_block;
        end
    end

    // ------------------------------------------------------------------------
    // Misalignment and read paths.
    // ------------------------------------------------------------------------

    always_comb begin
        case (i_store_type)
            cache_access_pkg::STORE_HALF:   o_store_addr_ma = byte_offset[0];
            cache_access_pkg::STORE_WORD:   o_store_addr_ma = |byte_offset;
            cache_access_pkg::STORE_DOUBLE: o_store_addr_ma = (|byte_offset) | word_offset[0];
            default:                        o_store_addr_ma = 1'b0;
        endcase
    end

    // Zero word on top pads the window at the last offset.
    assign read_ext     = {{WORD_WIDTH{1'b0}}, match_block};
    assign o_data       = read_ext[word_offset*WORD_WIDTH +: DATA_WIDTH];
    assign o_data_block = data_mem[way_if.index][way_if.victim_way];

endmodule

/* hw/dcache_lru.sv */
`timescale 1ns/1ps

module dcache_lru #(
    parameter int SET_COUNT = cache_geometry_pkg::DEF_SET_COUNT
) (
    input  logic          clk,
    input  logic          arst,
    input  logic          lru_update,
    dcache_way_if.replace way_if
);

    localparam int WAY_COUNT = cache_geometry_pkg::WAY_COUNT;
    localparam int WAY_W     = $clog2(WAY_COUNT);

    logic [WAY_W-1:0] rank_mem [SET_COUNT][WAY_COUNT];
    logic [SET_COUNT-1:0] set_touched;

    logic [WAY_W-1:0] rank_eff [WAY_COUNT];
    logic [WAY_W-1:0] victim;

    // Untouched sets rank the ways in order.
    always_comb begin
        victim = '0;
        for (int w = WAY_COUNT - 1; w >= 0; w--) begin
            rank_eff[w] = set_touched[way_if.index] ? rank_mem[way_if.index][w] : WAY_W'(w);
            if (rank_eff[w] == '0) begin
                victim = WAY_W'(w);
            end
        end
    end

    assign way_if.victim_way = victim;

    // Accessed way goes to the top, the ones above it move down.
    always_ff @(posedge clk) begin
        if (lru_update) begin
            for (int w = 0; w < WAY_COUNT; w++) begin
                if (WAY_W'(w) == way_if.match_way) begin
                    rank_mem[way_if.index][w] <= WAY_W'(WAY_COUNT - 1);
                end else if (rank_eff[w] > rank_eff[way_if.match_way]) begin
                    rank_mem[way_if.index][w] <= rank_eff[w] - 1'b1;
                end else begin
                    rank_mem[way_if.index][w] <= rank_eff[w];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            set_touched <= '0;
        end else if (lru_update) begin
            set_touched[way_if.index] <= 1'b1;
        end
    end

endmodule

/* hw/dcache_tag_store.sv */
`timescale 1ns/1ps

module dcache_tag_store #(
    parameter int SET_COUNT   = cache_geometry_pkg::DEF_SET_COUNT,
    parameter int BLOCK_WIDTH = cache_geometry_pkg::DEF_BLOCK_WIDTH,
    parameter int ADDR_WIDTH  = cache_geometry_pkg::DEF_ADDR_WIDTH
) (
    input  logic                                      clk,
    input  logic                                      arst,
    input  logic                                      write_en,
    input  logic                                      block_write_en,
    input  logic                                      valid_update,
    input  logic [ADDR_WIDTH-1:0]                     i_data_addr,
    input  logic                                      i_addr_control,
    output logic                                      o_hit,
    output logic                                      o_dirty,
    output logic [cache_geometry_pkg::BUS_ADDR_WIDTH-1:0] o_addr_axi,
    dcache_way_if.lookup                              way_if
);

    localparam int WAY_COUNT     = cache_geometry_pkg::WAY_COUNT;
    localparam int WAY_W         = $clog2(WAY_COUNT);
    localparam int WORD_OFFSET_W = $clog2(BLOCK_WIDTH / cache_geometry_pkg::WORD_WIDTH);
    localparam int INDEX_W       = $clog2(SET_COUNT);
    localparam int INDEX_LSB     = WORD_OFFSET_W + cache_geometry_pkg::BYTE_OFFSET_W;
    localparam int TAG_LSB       = INDEX_LSB + INDEX_W;
    localparam int TAG_W         = ADDR_WIDTH - TAG_LSB;
    localparam int BUS_W         = cache_geometry_pkg::BUS_ADDR_WIDTH;
    localparam int WB_TAG_W      = BUS_W - TAG_LSB;

    logic [TAG_W-1:0]   tag_in;
    logic [INDEX_W-1:0] index;
    logic [WAY_W-1:0]   victim;
    logic [WAY_W-1:0]   match;
    logic [WAY_COUNT-1:0] way_hit;

    logic [TAG_W-1:0] tag_mem [SET_COUNT][WAY_COUNT];
    logic [SET_COUNT-1:0][WAY_COUNT-1:0] valid_mem;
    logic [SET_COUNT-1:0][WAY_COUNT-1:0] dirty_mem;

    logic [BUS_W-1:0] miss_addr;
    logic [BUS_W-1:0] wb_addr;

    assign tag_in = i_data_addr[ADDR_WIDTH-1:TAG_LSB];
    assign index  = i_data_addr[TAG_LSB-1:INDEX_LSB];
    assign victim = way_if.victim_way;

    // ------------------------------------------------------------------------
    // Hit lookup.
    // ------------------------------------------------------------------------

    always_comb begin
        match = victim;
        for (int w = WAY_COUNT - 1; w >= 0; w--) begin
            way_hit[w] = valid_mem[index][w] & (tag_mem[index][w] == tag_in);
            if (way_hit[w]) begin
                match = WAY_W'(w);
            end
        end
    end

    assign o_hit            = |way_hit;
    assign way_if.hit       = o_hit;
    assign way_if.match_way = match;
    assign way_if.index     = index;

    // ------------------------------------------------------------------------
    // Tag, valid and dirty updates.
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (block_write_en) begin
            tag_mem[index][victim] <= tag_in;
        end
    end

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            valid_mem <= '0;
        end else if (valid_update) begin
            valid_mem[index][victim] <= 1'b1;
        end
    end

    // A store marks the line dirty, a refill leaves it clean.
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            dirty_mem <= '0;
        end else if (write_en) begin
            dirty_mem[index][match] <= 1'b1;
        end else if (block_write_en) begin
            dirty_mem[index][victim] <= 1'b0;
        end
    end

    assign o_dirty = dirty_mem[index][victim];

    // Block aligned bus addresses.
    assign miss_addr  = {i_data_addr[BUS_W-1:INDEX_LSB], {INDEX_LSB{1'b0}}};
    assign wb_addr    = {tag_mem[index][victim][WB_TAG_W-1:0], index, {INDEX_LSB{1'b0}}};
    assign o_addr_axi = i_addr_control ? miss_addr : wb_addr;

endmodule

/* hw/dcache_way_if.sv */
`timescale 1ns/1ps

interface dcache_way_if #(
    parameter int SET_COUNT = cache_geometry_pkg::DEF_SET_COUNT
);

    localparam int INDEX_W = $clog2(SET_COUNT);
    localparam int WAY_W   = $clog2(cache_geometry_pkg::WAY_COUNT);

    logic [INDEX_W-1:0] index;
    logic [WAY_W-1:0]   match_way;
    logic [WAY_W-1:0]   victim_way;
    logic               hit;

    modport lookup (output index, output match_way, output hit, input victim_way);

    modport replace (input index, input match_way, input hit, output victim_way);

    modport data (input index, input match_way, input hit, input victim_way);

endinterface

/* hw/cache_access_pkg.sv */
package cache_access_pkg;

    // ------------------------------------------------------------------------
    // Store type encoding.
    // ------------------------------------------------------------------------

    localparam int STORE_TYPE_W = 2;

    localparam logic [STORE_TYPE_W-1:0] STORE_BYTE   = 2'd0;
    localparam logic [STORE_TYPE_W-1:0] STORE_HALF   = 2'd1;
    localparam logic [STORE_TYPE_W-1:0] STORE_WORD   = 2'd2;
    localparam logic [STORE_TYPE_W-1:0] STORE_DOUBLE = 2'd3;

    // ------------------------------------------------------------------------
    // Lane widths in bits.
    // ------------------------------------------------------------------------

    localparam int LANE_BYTE_W   = 8;
    localparam int LANE_HALF_W   = 16;
    localparam int LANE_WORD_W   = 32;
    localparam int LANE_DOUBLE_W = 64;

endpackage

/* hw/cache_geometry_pkg.sv */
package cache_geometry_pkg;

    // ------------------------------------------------------------------------
    // Associativity.
    // ------------------------------------------------------------------------

    // Two ways per set.
    localparam int WAY_COUNT = 2;

    // ------------------------------------------------------------------------
    // Default geometry, overridable from the top level.
    // ------------------------------------------------------------------------

    localparam int DEF_SET_COUNT   = 2;
    localparam int DEF_BLOCK_WIDTH = 512;
    localparam int DEF_ADDR_WIDTH  = 64;

    // ------------------------------------------------------------------------
    // Fixed widths.
    // ------------------------------------------------------------------------

    // Address width on the memory bus side.
    localparam int BUS_ADDR_WIDTH = 32;

    // One core register.
    localparam int DATA_WIDTH = 64;

    // Unit counted by the word offset field.
    localparam int WORD_WIDTH    = 32;
    localparam int BYTE_OFFSET_W = 2;

endpackage
